/* common/vgatest_defs.svh */
`ifndef VGATEST_DEFS_SVH
`define VGATEST_DEFS_SVH

// 640x480 @ 60 Hz, horizontal in pixels
`define H_VISIBLE   640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48
`define H_TOTAL     800

// vertical in lines
`define V_VISIBLE   480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33
`define V_TOTAL     525

// position counter widths
`define X_BITS      10
`define Y_BITS      10

// bit 19 sets after about 21 ms at 25 MHz
`define RELOAD_BITS 20

// top bits drive the blinky LEDs
`define BLINK_BITS  28

`endif

/* common/vgatest_pkg.sv */
`default_nettype none

`include "vgatest_defs.svh"

package vgatest_pkg;

  // one pixel colour
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // pixel stream, one beat per clock
  typedef struct packed {
    logic [`X_BITS-1:0] x;
    logic [`Y_BITS-1:0] y;
    logic               hsync;  // active low
    logic               vsync;  // active low
    logic               blank;
    rgb_t               pix;
  } video_t;

  // parallel 10-bit words, one per channel
  typedef struct packed {
    logic [9:0] red;
    logic [9:0] green;
    logic [9:0] blue;
  } tmds_t;

  typedef enum logic [1:0] {
    PAT_BARS     = 2'd0,
    PAT_GRADIENT = 2'd1,
    PAT_GRID     = 2'd2,
    PAT_SOLID    = 2'd3
  } pattern_e;

endpackage

`default_nettype wire

/* vga/vga_timing.sv */
`default_nettype none

`include "vgatest_defs.svh"

module vga_timing
(
  input  wire logic          clk_25mhz,
  input  wire logic          arst_n_i,
  output vgatest_pkg::video_t timing_o
);

  localparam int HS_START = `H_VISIBLE + `H_FRONT;  // 656
  localparam int HS_END   = HS_START + `H_SYNC;      // first x after sync
  localparam int VS_START = `V_VISIBLE + `V_FRONT;  // 490
  localparam int VS_END   = VS_START + `V_SYNC;

  localparam logic [`X_BITS-1:0] X_LAST = `X_BITS'(`H_TOTAL - 1);
  localparam logic [`Y_BITS-1:0] Y_LAST = `Y_BITS'(`V_TOTAL - 1);

  logic [`X_BITS-1:0] x_q;
  logic [`Y_BITS-1:0] y_q;
  logic               x_last;
  logic               y_last;

  assign x_last = (x_q == X_LAST);
  assign y_last = (y_q == Y_LAST);

  // position counters
  always_ff @(posedge clk_25mhz or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      x_q <= '0;
      y_q <= '0;
    end
    else if (x_last)
    begin
      x_q <= '0;
      y_q <= y_last ? '0 : y_q + 1'b1;  // next line or next frame
    end
    else
    begin
      x_q <= x_q + 1'b1;
    end
  end

  // flags follow the counter one edge later
  always_ff @(posedge clk_25mhz or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      timing_o       <= '0;
      timing_o.hsync <= 1'b1;
      timing_o.vsync <= 1'b1;
      timing_o.blank <= 1'b1;
    end
    else
    begin
      timing_o.x     <= x_q;
      timing_o.y     <= y_q;
      timing_o.hsync <= !((x_q >= HS_START) && (x_q < HS_END));
      timing_o.vsync <= !((y_q >= VS_START) && (y_q < VS_END));
      timing_o.blank <= (x_q >= `H_VISIBLE) || (y_q >= `V_VISIBLE);
      timing_o.pix   <= '0;  // colour added downstream
    end
  end

  counter_range_a: assert property (@(posedge clk_25mhz) disable iff (!arst_n_i)
    (x_q < `H_TOTAL) && (y_q < `V_TOTAL));

endmodule

`default_nettype wire

/* vga/test_pattern.sv */
`default_nettype none

`include "vgatest_defs.svh"

module test_pattern
(
  input  wire logic               clk_25mhz,
  input  wire logic               arst_n_i,
  input  wire logic [1:0]         sel_i,     // raw button bits
  input  wire vgatest_pkg::video_t timing_i,
  output vgatest_pkg::video_t      video_o
);

  import vgatest_pkg::*;

  localparam int BAR_W = `H_VISIBLE / 8;  // 80 pixels per bar

  pattern_e sel_pat;
  pattern_e frame_pat_q;
  pattern_e pat;
  logic     frame_start;
  logic     grid_line;
  logic [2:0] bar_idx;
  rgb_t     colour;

  assign sel_pat     = pattern_e'(sel_i);
  assign frame_start = (timing_i.x == '0) && (timing_i.y == '0);
  // first pixel already uses the new choice
  assign pat         = frame_start ? sel_pat : frame_pat_q;
  assign bar_idx     = 3'(timing_i.x / BAR_W);
  assign grid_line   = (timing_i.x[4:0] == 5'd0) || (timing_i.y[4:0] == 5'd0);

  always_comb
  begin
    case (pat)
      PAT_BARS:
        colour = '{r: {8{bar_idx[2]}}, g: {8{bar_idx[1]}}, b: {8{bar_idx[0]}}};
      PAT_GRADIENT:
        colour = '{r: timing_i.x[7:0], g: timing_i.y[7:0],
                   b: timing_i.x[7:0] ^ timing_i.y[7:0]};
      PAT_GRID:
        colour = grid_line ? 24'hff_ff_ff : 24'h00_00_00;
      default:
        colour = '{r: 8'h00, g: 8'h00, b: 8'hff};  // solid blue
    endcase
  end

  always_ff @(posedge clk_25mhz or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      frame_pat_q   <= PAT_BARS;
      video_o       <= '0;
      video_o.hsync <= 1'b1;
      video_o.vsync <= 1'b1;
      video_o.blank <= 1'b1;
    end
    else
    begin
      if (frame_start)
        frame_pat_q <= sel_pat;  // held for the whole frame
      video_o.x     <= timing_i.x;
      video_o.y     <= timing_i.y;
      video_o.hsync <= timing_i.hsync;
      video_o.vsync <= timing_i.vsync;
      video_o.blank <= timing_i.blank;
      video_o.pix   <= timing_i.blank ? 24'h00_00_00 : colour;
    end
  end

endmodule

`default_nettype wire

/* dvid/tmds_encoder.sv */
`default_nettype none

module tmds_encoder
#(
  parameter logic [1:0] RESET_CTRL = 2'b00  // control symbol shown in reset
)
(
  input  wire logic       clk_25mhz,
  input  wire logic       arst_n_i,
  input  wire logic [7:0] data_i,
  input  wire logic [1:0] ctrl_i,
  input  wire logic       blank_i,
  output logic      [9:0] tmds_o
);

  function automatic logic [9:0] ctrl_word(input logic [1:0] c);
    case (c)
      2'b00:   ctrl_word = 10'b1101010100;
      2'b01:   ctrl_word = 10'b0010101011;
      2'b10:   ctrl_word = 10'b0101010100;
      default: ctrl_word = 10'b1010101011;
    endcase
  endfunction

  logic [3:0]        n1_d;
  logic [3:0]        n1_q;
  logic [3:0]        n0_q;
  logic              use_xnor;
  logic [8:0]        q_m;
  logic signed [4:0] bal;     // ones minus zeros of q_m[7:0]
  logic signed [4:0] disp_q;  // running disparity
  logic signed [4:0] disp_d;
  logic [9:0]        word_d;

  // stage 1 transition minimisation
  assign n1_d     = 4'($countones(data_i));
  assign use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data_i[0]);

  always_comb
  begin
    q_m[0] = data_i[0];
    for (int i = 1; i < 8; i++)
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_i[i]) : (q_m[i-1] ^ data_i[i]);
    q_m[8] = ~use_xnor;
  end

  assign n1_q = 4'($countones(q_m[7:0]));
  assign n0_q = 4'd8 - n1_q;
  assign bal  = $signed({1'b0, n1_q}) - $signed({1'b0, n0_q});

  // stage 2 dc balance
  always_comb
  begin
    if (blank_i)
    begin
      word_d = ctrl_word(ctrl_i);
      disp_d = '0;
    end
    else if ((disp_q == 0) || (bal == 0))
    begin
      word_d = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      disp_d = q_m[8] ? disp_q + bal : disp_q - bal;
    end
    else if (((disp_q > 0) && (bal > 0)) || ((disp_q < 0) && (bal < 0)))
    begin
      word_d = {1'b1, q_m[8], ~q_m[7:0]};  // invert to pull back toward zero
      disp_d = disp_q - bal + (q_m[8] ? 5'sd2 : 5'sd0);
    end
    else
    begin
      word_d = {1'b0, q_m[8], q_m[7:0]};
      disp_d = disp_q + bal - (q_m[8] ? 5'sd0 : 5'sd2);
    end
  end

  always_ff @(posedge clk_25mhz or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      tmds_o <= ctrl_word(RESET_CTRL);
      disp_q <= '0;
    end
    else
    begin
      tmds_o <= word_d;
      disp_q <= disp_d;
    end
  end

  // control words exactly while blanked, data words never alias them
  blank_ctrl_a: assert property (@(posedge clk_25mhz) disable iff (!arst_n_i)
    1'b1 |=> ((tmds_o inside {10'b1101010100, 10'b0010101011,
                              10'b0101010100, 10'b1010101011}) == $past(blank_i)));

  // running disparity stays even and within 8 either way
  disp_range_a: assert property (@(posedge clk_25mhz) disable iff (!arst_n_i)
    !disp_q[0] && (disp_q >= -5'sd8) && (disp_q <= 5'sd8));

endmodule

`default_nettype wire

/* dvid/dvi_encoder.sv */
`default_nettype none

module dvi_encoder
(
  input  wire logic               clk_25mhz,
  input  wire logic               arst_n_i,
  input  wire vgatest_pkg::video_t video_i,
  output vgatest_pkg::tmds_t       tmds_o
);

  logic [9:0] red_s;
  logic [9:0] green_s;
  logic [9:0] blue_s;

  tmds_encoder #(.RESET_CTRL(2'b00)) i_tmds_red (
    .clk_25mhz (clk_25mhz),
    .arst_n_i  (arst_n_i),
    .data_i    (video_i.pix.r),
    .ctrl_i    (2'b00),
    .blank_i   (video_i.blank),
    .tmds_o    (red_s)
  );

  tmds_encoder #(.RESET_CTRL(2'b00)) i_tmds_green (
    .clk_25mhz (clk_25mhz),
    .arst_n_i  (arst_n_i),
    .data_i    (video_i.pix.g),
    .ctrl_i    (2'b00),
    .blank_i   (video_i.blank),
    .tmds_o    (green_s)
  );

  // syncs ride on blue, idle high in reset
  tmds_encoder #(.RESET_CTRL(2'b11)) i_tmds_blue (
    .clk_25mhz (clk_25mhz),
    .arst_n_i  (arst_n_i),
    .data_i    (video_i.pix.b),
    .ctrl_i    ({video_i.vsync, video_i.hsync}),
    .blank_i   (video_i.blank),
    .tmds_o    (blue_s)
  );

  assign tmds_o = '{red: red_s, green: green_s, blue: blue_s};

endmodule

`default_nettype wire

/* source/board_ctrl.sv */
`default_nettype none

`include "vgatest_defs.svh"

module board_ctrl
(
  input  wire logic               clk_25mhz,
  input  wire logic               arst_n_i,
  input  wire logic               btn0_i,
  input  wire vgatest_pkg::video_t video_i,
  output logic [7:0]               led_o,
  output logic                     user_programn_o,
  output logic                     wifi_gpio0_o
);

  logic [`RELOAD_BITS-1:0] reload_q;
  logic [`BLINK_BITS-1:0]  blink_q;
  logic                    reload_done;

  assign reload_done = reload_q[`RELOAD_BITS-1];

  // low pulls PROGRAMN and leaves this bitstream
  assign user_programn_o = btn0_i | ~reload_done;
  // held high the ESP32 keeps its hands off the board
  assign wifi_gpio0_o    = btn0_i;

  always_ff @(posedge clk_25mhz or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      reload_q <= '0;
      blink_q  <= '0;
      led_o    <= '0;
    end
    else
    begin
      if (!reload_done)
        reload_q <= reload_q + 1'b1;  // stops once top bit sets
      blink_q <= blink_q + 1'b1;
      led_o   <= {blink_q[`BLINK_BITS-1 -: 5],
                  video_i.blank, video_i.hsync, video_i.vsync};
    end
  end

endmodule

`default_nettype wire

/* source/vgatest_top.sv */
`default_nettype none

module vgatest_top
(
  input  wire logic         clk_25mhz,   // also the pixel clock
  input  wire logic         arst_n_i,
  input  wire logic [6:0]   btn_i,       // 6:3 spare
  output vgatest_pkg::tmds_t tmds_o,
  output logic [7:0]         led_o,
  output logic               user_programn_o,
  output logic               wifi_gpio0_o
);

  import vgatest_pkg::*;

  video_t timing_s;  // positions and syncs
  video_t video_s;   // same with colour

  vga_timing i_vga_timing (
    .clk_25mhz (clk_25mhz),
    .arst_n_i  (arst_n_i),
    .timing_o  (timing_s)
  );

  test_pattern i_test_pattern (
    .clk_25mhz (clk_25mhz),
    .arst_n_i  (arst_n_i),
    .sel_i     (btn_i[2:1]),
    .timing_i  (timing_s),
    .video_o   (video_s)
  );

  dvi_encoder i_dvi_encoder (
    .clk_25mhz (clk_25mhz),
    .arst_n_i  (arst_n_i),
    .video_i   (video_s),
    .tmds_o    (tmds_o)
  );

  // housekeeping
  board_ctrl i_board_ctrl (
    .clk_25mhz       (clk_25mhz),
    .arst_n_i        (arst_n_i),
    .btn0_i          (btn_i[0]),
    .video_i         (video_s),
    .led_o           (led_o),
    .user_programn_o (user_programn_o),
    .wifi_gpio0_o    (wifi_gpio0_o)
  );

endmodule

`default_nettype wire

/* dv/vgatest_model.svh */
`ifndef VGATEST_MODEL_SVH
`define VGATEST_MODEL_SVH

// {blank, hsync, vsync} at one position, syncs active low
function automatic logic [2:0] model_timing(input int x, input int y);
  logic blank;
  logic hsync;
  logic vsync;
  blank = (x >= `H_VISIBLE) || (y >= `V_VISIBLE);
  hsync = !((x >= (`H_VISIBLE + `H_FRONT)) && (x < (`H_VISIBLE + `H_FRONT + `H_SYNC)));
  vsync = !((y >= (`V_VISIBLE + `V_FRONT)) && (y < (`V_VISIBLE + `V_FRONT + `V_SYNC)));
  return {blank, hsync, vsync};
endfunction

// expected {r, g, b}, black outside the visible area
function automatic logic [23:0] model_pixel(input pattern_e pat, input int x, input int y);
  logic [2:0] flags;
  int         bar;
  flags = model_timing(x, y);
  bar   = x / (`H_VISIBLE / 8);
  if (flags[2])
    return 24'h000000;
  case (pat)
    PAT_BARS:     return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
    PAT_GRADIENT: return {8'(x), 8'(y), 8'(x ^ y)};
    PAT_GRID:     return ((x % 32 == 0) || (y % 32 == 0)) ? 24'hffffff : 24'h000000;
    default:      return 24'h0000ff;
  endcase
endfunction

// one DVI channel, disp is the channel's running disparity
function automatic logic [9:0] model_tmds(input logic [7:0] d, input logic [1:0] c,
                                          input logic blank, ref int disp);
  logic [8:0] qm;
  logic       use_xnor;
  int         ones_d;
  int         n1;
  int         n0;
  int         i;
  if (blank)
  begin
    disp = 0;
    case (c)
      2'b00:   return 10'b1101010100;
      2'b01:   return 10'b0010101011;
      2'b10:   return 10'b0101010100;
      default: return 10'b1010101011;
    endcase
  end
  ones_d = 0;
  for (i = 0; i < 8; i++)
    if (d[i])
      ones_d++;
  use_xnor = (ones_d > 4) || ((ones_d == 4) && !d[0]);
  qm[0] = d[0];
  for (i = 1; i < 8; i++)
    qm[i] = use_xnor ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
  qm[8] = !use_xnor;
  n1 = 0;
  for (i = 0; i < 8; i++)
    if (qm[i])
      n1++;
  n0 = 8 - n1;
  if ((disp == 0) || (n1 == n0))
  begin
    disp = qm[8] ? disp + n1 - n0 : disp + n0 - n1;
    return {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
  end
  if (((disp > 0) && (n1 > n0)) || ((disp < 0) && (n0 > n1)))
  begin
    disp = disp + (qm[8] ? 2 : 0) + n0 - n1;  // inverted word
    return {1'b1, qm[8], ~qm[7:0]};
  end
  disp = disp - (qm[8] ? 0 : 2) + n1 - n0;
  return {1'b0, qm[8], qm[7:0]};
endfunction

`endif

/* dv/vgatest_tb.sv */
`default_nettype none

`include "vgatest_defs.svh"

module vgatest_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import vgatest_pkg::*;

  `include "vgatest_model.svh"

  localparam int FRAME       = `H_TOTAL * `V_TOTAL;  // clocks per frame
  localparam int LATENCY     = 3;
  localparam int FRAMES      = 4;
  localparam int LIMIT       = 5 * FRAME + 10000;
  localparam int RELOAD_EDGE = 1 << (`RELOAD_BITS - 1);

  logic       clk_25mhz;
  logic       arst_n_i;
  logic [6:0] btn_i;
  tmds_t      tmds_o;
  logic [7:0] led_o;
  logic       user_programn_o;
  logic       wifi_gpio0_o;

  logic [1:0] pat_sel = 2'b00;  // bars in frame 0
  logic       btn0 = 1'b0;
  integer     seed = 65072;
  int         cycle_cnt = 0;
  int         edge_n = 0;       // edges since reset release
  int         disp_r = 0;
  int         disp_g = 0;
  int         disp_b = 0;
  logic [1:0] cur_pat = 2'b00;
  logic [1:0] pat_d1 = 2'b00;
  logic [1:0] pat_d2 = 2'b00;
  logic [3:0] seen_pat = 4'b0000;
  logic       run_done = 1'b0;

  assign btn_i = {4'b0000, pat_sel, btn0};

  vgatest_top i_vgatest_top (
    .clk_25mhz       (clk_25mhz),
    .arst_n_i        (arst_n_i),
    .btn_i           (btn_i),
    .tmds_o          (tmds_o),
    .led_o           (led_o),
    .user_programn_o (user_programn_o),
    .wifi_gpio0_o    (wifi_gpio0_o)
  );

  initial
    clk_25mhz = 1'b0;

  always #20 clk_25mhz = ~clk_25mhz;

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    if (exp !== got)
    begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // reset, then one new pattern in the middle of frames 0 to 2
  initial
  begin
    logic [3:0] used;
    logic [1:0] next_pat;
    int         left;
    int         pick;
    int         f;
    int         p;
    arst_n_i = 1'b0;
    used     = 4'b0001;
    next_pat = 2'b00;
    repeat (8) @(posedge clk_25mhz);
    arst_n_i <= 1'b1;
    repeat (FRAME / 2) @(posedge clk_25mhz);
    for (f = 0; f < FRAMES - 1; f++)
    begin
      left = 4 - $countones(used);
      pick = int'($unsigned($random(seed)) % left);
      for (p = 0; p < 4; p++)
      begin
        if (!used[p])
        begin
          if (pick == 0)
            next_pat = 2'(p);
          pick = pick - 1;
        end
      end
      used[next_pat] = 1'b1;  // every pattern once over four frames
      pat_sel <= next_pat;
      repeat (FRAME) @(posedge clk_25mhz);
    end
  end

  // exit button, one pulse inside the reload delay and one after it
  initial
  begin
    repeat (8 + 100000) @(posedge clk_25mhz);
    btn0 <= 1'b1;
    repeat (500) @(posedge clk_25mhz);
    btn0 <= 1'b0;
    repeat (RELOAD_EDGE) @(posedge clk_25mhz);
    btn0 <= 1'b1;
    repeat (500) @(posedge clk_25mhz);
    btn0 <= 1'b0;
  end

  // outputs are stable at the falling edge
  always @(negedge clk_25mhz)
  begin
    logic [2:0]  flags;
    logic [23:0] rgb;
    tmds_t       exp_tmds;
    int          pix;
    int          px;
    int          py;
    if (arst_n_i && !run_done)
    begin
      // pixel edge_n-1 enters the pattern stage at the next edge
      if ((edge_n >= 1) && ((edge_n - 1) % FRAME == 0))
        cur_pat = btn_i[2:1];
      if (edge_n < LATENCY)
      begin
        check_value("tmds_o.red", 32'(10'b1101010100), 32'(tmds_o.red));
        check_value("tmds_o.green", 32'(10'b1101010100), 32'(tmds_o.green));
        check_value("tmds_o.blue", 32'(10'b1010101011), 32'(tmds_o.blue));
        check_value("led_o[2:0]", (edge_n == 0) ? 32'h0 : 32'h7, 32'(led_o[2:0]));
      end
      else
      begin
        pix = edge_n - LATENCY;
        px  = pix % `H_TOTAL;
        py  = (pix / `H_TOTAL) % `V_TOTAL;
        if ((px == 0) && (py == 0))
          seen_pat[pat_d2] = 1'b1;
        flags          = model_timing(px, py);
        rgb            = model_pixel(pattern_e'(pat_d2), px, py);
        exp_tmds.red   = model_tmds(rgb[23:16], 2'b00, flags[2], disp_r);
        exp_tmds.green = model_tmds(rgb[15:8], 2'b00, flags[2], disp_g);
        exp_tmds.blue  = model_tmds(rgb[7:0], {flags[0], flags[1]}, flags[2], disp_b);
        check_value("tmds_o.red", 32'(exp_tmds.red), 32'(tmds_o.red));
        check_value("tmds_o.green", 32'(exp_tmds.green), 32'(tmds_o.green));
        check_value("tmds_o.blue", 32'(exp_tmds.blue), 32'(tmds_o.blue));
        check_value("led_o[2:0]", 32'(flags), 32'(led_o[2:0]));
      end
      check_value("led_o[7:3]", (edge_n == 0) ? 32'h0 : 32'(((edge_n - 1) >> 23) & 31),
                  32'(led_o[7:3]));
      check_value("user_programn_o", 32'(btn0 | (edge_n < RELOAD_EDGE)),
                  32'(user_programn_o));
      check_value("wifi_gpio0_o", 32'(btn0), 32'(wifi_gpio0_o));
      pat_d2 = pat_d1;   // pattern follows its pixel down the pipeline
      pat_d1 = cur_pat;
      edge_n = edge_n + 1;
      if (edge_n == FRAMES * FRAME + LATENCY)
        run_done = 1'b1;
    end
  end

  always @(posedge clk_25mhz)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == LIMIT)
    begin
      $display("timeout: stimulus did not finish");
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  initial
  begin
    wait (run_done);
    if (seen_pat == 4'hf)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("not every pattern was shown, seen mask %h", seen_pat);
      $display("Simulation failed");
      $fatal(1, "pattern coverage incomplete");
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
+incdir+dv
common/vgatest_pkg.sv
vga/vga_timing.sv
vga/test_pattern.sv
dvid/tmds_encoder.sv
dvid/dvi_encoder.sv
source/board_ctrl.sv
source/vgatest_top.sv
dv/vgatest_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module vgatest_tb -Mdir obj_dir
	./obj_dir/Vvgatest_tb | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
